// File: Makefile
# Verilator simulation of the analog data path

LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_analog_top -f verilog.f --Mdir obj_dir
	./obj_dir/Vtb_analog_top | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: hdl/adc_front.sv
// ADC front end
// Registers both ADC words, drops reserved bits, converts the
// neg-slope code to two's complement, optional digital loopback

`timescale 1ns/1ps
`default_nettype none

module adc_front
  import analog_pkg::*;
(
  input  logic     adc_clk,
  input  logic     adc_rstn,
  // ADC pins
  input  adc_raw_t adc_dat_a_i,     // CH A raw word
  input  adc_raw_t adc_dat_b_i,     // CH B raw word
  // Loopback
  input  logic     digital_loop_i,  // Level, selects loop samples
  input  sample_t  loop_a_i,        // Mixed output CH A
  input  sample_t  loop_b_i,        // Mixed output CH B
  // Converted samples
  output sample_t  adc_a_o,
  output sample_t  adc_b_o
);

  ////////////////////
  // Input registers
  ////////////////////

  logic [SAMPLE_W-1:0] raw_a_q;  // Neg-slope code, reserved bits gone
  logic [SAMPLE_W-1:0] raw_b_q;
  sample_t             conv_a;   // Two's complement
  sample_t             conv_b;

  // Should map onto IOB registers
  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      raw_a_q <= '0;
      raw_b_q <= '0;
    end else begin
      raw_a_q <= adc_dat_a_i[ADC_RAW_W-1:ADC_RSV_W];
      raw_b_q <= adc_dat_b_i[ADC_RAW_W-1:ADC_RSV_W];
    end
  end

  ////////////////////
  // Conversion
  ////////////////////

  assign conv_a = neg_slope(raw_a_q);  // Keep sign, invert rest
  assign conv_b = neg_slope(raw_b_q);

  // Loopback bypasses the ADC entirely
  // Combinational from the mixer, no extra latency
  assign adc_a_o = digital_loop_i ? loop_a_i : conv_a;
  assign adc_b_o = digital_loop_i ? loop_b_i : conv_b;

endmodule

`default_nettype wire

// File: hdl/analog_pkg.sv
// Analog data path shared definitions
// Sample widths, averaging window and the neg-slope code mapping
// used by the ADC front end and the DAC output stage

`default_nettype none

package analog_pkg;

  ////////////////////
  // Widths
  ////////////////////

  localparam int ADC_RAW_W    = 16;  // Raw ADC bus word
  localparam int SAMPLE_W     = 14;  // Processed sample
  localparam int ADC_RSV_W    = 2;   // Reserved low ADC bits, dropped
  localparam int WIN_LOG2_DEF = 6;   // 64 sample window

  ////////////////////
  // Vector types
  ////////////////////

  typedef logic        [ADC_RAW_W-1:0] adc_raw_t;   // Raw ADC word
  typedef logic signed [SAMPLE_W-1:0]  sample_t;    // Two's complement sample
  typedef logic        [SAMPLE_W-1:0]  dac_code_t;  // Neg-slope DAC code
  typedef logic signed [SAMPLE_W:0]    mix_sum_t;   // One guard bit for the sum

  // Neg-slope <-> two's complement, same mapping both ways
  // Sign bit stays, magnitude bits flip
  function automatic logic [SAMPLE_W-1:0] neg_slope(input logic [SAMPLE_W-1:0] val);
    return {val[SAMPLE_W-1], ~val[SAMPLE_W-2:0]};
  endfunction

endpackage

`default_nettype wire

// File: hdl/analog_top.sv
// Analog data path top level
// ADC capture with loopback, generator and controller mixing,
// per channel moving average and neg-slope DAC outputs

`timescale 1ns/1ps
`default_nettype none

module analog_top
  import analog_pkg::*;
#(
  parameter int WIN_LOG2 = WIN_LOG2_DEF  // log2 of averaging window
) (
  input  logic      adc_clk,
  input  logic      adc_rstn,
  // ADC
  input  adc_raw_t  adc_dat_a_i,
  input  adc_raw_t  adc_dat_b_i,
  input  logic      digital_loop_i,  // Replace ADC with mixed outputs
  // Generator and controller samples
  input  sample_t   asg_a_i,
  input  sample_t   asg_b_i,
  input  sample_t   pid_a_i,
  input  sample_t   pid_b_i,
  // Converted ADC samples
  output sample_t   adc_a_o,
  output sample_t   adc_b_o,
  // DAC
  output dac_code_t dac_a_o,
  output dac_code_t dac_b_o,
  output logic      dac_sel_o,
  output logic      dac_rst_o
);

  sample_t mix_a;  // Saturated sums
  sample_t mix_b;
  sample_t avg_a;  // Window means
  sample_t avg_b;

  ////////////////////
  // ADC capture
  ////////////////////

  adc_front u_adc_front (
    .adc_clk        (adc_clk),
    .adc_rstn       (adc_rstn),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .digital_loop_i (digital_loop_i),
    .loop_a_i       (mix_a),   // Loopback source
    .loop_b_i       (mix_b),
    .adc_a_o        (adc_a_o),
    .adc_b_o        (adc_b_o)
  );

  ////////////////////
  // Mixing
  ////////////////////

  output_mixer u_output_mixer (
    .asg_a_i (asg_a_i),
    .asg_b_i (asg_b_i),
    .pid_a_i (pid_a_i),
    .pid_b_i (pid_b_i),
    .mix_a_o (mix_a),
    .mix_b_o (mix_b)
  );

  ////////////////////
  // Smoothing
  ////////////////////

  // Both channels average their own mixed output
  moving_average #(
    .WIN_LOG2 (WIN_LOG2)
  ) ma_a (
    .adc_clk  (adc_clk),
    .adc_rstn (adc_rstn),
    .smp_i    (mix_a),
    .avg_o    (avg_a)
  );

  moving_average #(
    .WIN_LOG2 (WIN_LOG2)
  ) ma_b (
    .adc_clk  (adc_clk),
    .adc_rstn (adc_rstn),
    .smp_i    (mix_b),
    .avg_o    (avg_b)
  );

  ////////////////////
  // DAC outputs
  ////////////////////

  dac_output u_dac_output (
    .adc_clk   (adc_clk),
    .adc_rstn  (adc_rstn),
    .avg_a_i   (avg_a),
    .avg_b_i   (avg_b),
    .dac_a_o   (dac_a_o),
    .dac_b_o   (dac_b_o),
    .dac_sel_o (dac_sel_o),
    .dac_rst_o (dac_rst_o)
  );

endmodule

`default_nettype wire

// File: hdl/dac_output.sv
// DAC output stage
// Registers the neg-slope code of each averaged channel,
// drives the channel-select strobe and the DAC reset level

`timescale 1ns/1ps
`default_nettype none

module dac_output
  import analog_pkg::*;
(
  input  logic      adc_clk,
  input  logic      adc_rstn,
  input  sample_t   avg_a_i,    // Averaged CH A
  input  sample_t   avg_b_i,    // Averaged CH B
  output dac_code_t dac_a_o,    // Neg-slope code CH A
  output dac_code_t dac_b_o,    // Neg-slope code CH B
  output logic      dac_sel_o,  // Channel select strobe
  output logic      dac_rst_o   // DAC reset, active high
);

  // Code of a zero sample
  localparam dac_code_t DAC_ZERO = {1'b0, {(SAMPLE_W-1){1'b1}}};

  dac_code_t dac_a_q;
  dac_code_t dac_b_q;
  logic      sel_q;
  logic      rst_q;

  ////////////////////
  // Output registers
  ////////////////////

  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      dac_a_q <= DAC_ZERO;  // Midscale while in reset
      dac_b_q <= DAC_ZERO;
      sel_q   <= 1'b0;
      rst_q   <= 1'b1;
    end else begin
      dac_a_q <= neg_slope(avg_a_i);  // Sign kept, rest inverted
      dac_b_q <= neg_slope(avg_b_i);
      sel_q   <= ~sel_q;              // Alternates every edge
      rst_q   <= 1'b0;                // Drops one edge after release
    end
  end

  assign dac_a_o   = dac_a_q;
  assign dac_b_o   = dac_b_q;
  assign dac_sel_o = sel_q;
  assign dac_rst_o = rst_q;

  ////////////////////
  // Checks
  ////////////////////

  // Strobe never stalls once the DAC is out of reset
  a_sel_alternates: assert property (
    @(posedge adc_clk) disable iff (!adc_rstn)
    !dac_rst_o |=> dac_sel_o != $past(dac_sel_o)
  ) else $error("dac_sel_o did not alternate");

endmodule

`default_nettype wire

// File: hdl/moving_average.sv
// Moving average, one channel
// Boxcar filter over 2**WIN_LOG2 samples: history memory,
// running sum and a wrapping write pointer

`timescale 1ns/1ps
`default_nettype none

module moving_average
  import analog_pkg::*;
#(
  parameter int WIN_LOG2 = WIN_LOG2_DEF  // Valid for 2 to 8
) (
  input  logic    adc_clk,
  input  logic    adc_rstn,
  input  sample_t smp_i,  // New sample every cycle
  output sample_t avg_o   // Window mean, floor
);

  localparam int WIN   = 1 << WIN_LOG2;         // Window length
  localparam int SUM_W = SAMPLE_W + WIN_LOG2;   // Holds WIN full scale samples

  typedef logic signed [SUM_W-1:0] sum_t;

  ////////////////////
  // State
  ////////////////////

  sample_t             hist_q [WIN];  // Last WIN samples
  logic [WIN_LOG2-1:0] ptr_q;         // Oldest slot, next write
  sum_t                sum_q;         // Sum over hist_q
  sample_t             old_smp;       // Sample leaving the window
  sum_t                sum_nxt;

  assign old_smp = hist_q[ptr_q];

  // Wrap in the intermediate is harmless, final value always fits
  assign sum_nxt = sum_q + sum_t'(smp_i) - sum_t'(old_smp);

  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      for (int i = 0; i < WIN; i++) begin
        hist_q[i] <= '0;  // Sum and history must agree
      end
      ptr_q <= '0;
      sum_q <= '0;
    end else begin
      hist_q[ptr_q] <= smp_i;        // Overwrite oldest
      ptr_q         <= ptr_q + 1'b1;  // Natural wrap at WIN
      sum_q         <= sum_nxt;
    end
  end

  ////////////////////
  // Output
  ////////////////////

  // Divide by WIN, drop low bits -> rounds toward minus infinity
  assign avg_o = sum_q[SUM_W-1:WIN_LOG2];

  ////////////////////
  // Checks
  ////////////////////

  sum_t hist_sum;  // Reference total of the history memory

  always_comb begin
    hist_sum = '0;
    for (int i = 0; i < WIN; i++) begin
      hist_sum = hist_sum + sum_t'(hist_q[i]);
    end
  end

  // Add and subtract path never drifts from the memory contents
  a_sum_matches_hist: assert property (
    @(posedge adc_clk) disable iff (!adc_rstn)
    sum_q == hist_sum
  ) else $error("running sum differs from history total");

  // Filter comes out of reset empty
  a_avg_zero_in_reset: assert property (
    @(posedge adc_clk)
    !adc_rstn |=> avg_o == '0
  ) else $error("average not cleared by reset");

endmodule

`default_nettype wire

// File: hdl/output_mixer.sv
// Output mixer
// Adds generator and controller samples per channel and
// saturates the result to the 14 bit sample range

`timescale 1ns/1ps
`default_nettype none

module output_mixer
  import analog_pkg::*;
(
  input  sample_t asg_a_i,  // Generator CH A
  input  sample_t asg_b_i,  // Generator CH B
  input  sample_t pid_a_i,  // Controller CH A
  input  sample_t pid_b_i,  // Controller CH B
  output sample_t mix_a_o,
  output sample_t mix_b_o
);

  // Sample range limits in sum width
  localparam mix_sum_t SUM_MAX = mix_sum_t'(2**(SAMPLE_W-1) - 1);
  localparam mix_sum_t SUM_MIN = -mix_sum_t'(2**(SAMPLE_W-1));

  mix_sum_t sum_a;  // Unsaturated, one guard bit
  mix_sum_t sum_b;

  // Clamp on overflow, direction from the sum sign
  function automatic sample_t saturate(input mix_sum_t s);
    if (s[SAMPLE_W] != s[SAMPLE_W-1]) begin  // Top two bits differ
      return {s[SAMPLE_W], {(SAMPLE_W-1){~s[SAMPLE_W]}}};
    end
    return s[SAMPLE_W-1:0];
  endfunction

  ////////////////////
  // Sum and clamp
  ////////////////////

  assign sum_a = mix_sum_t'(asg_a_i) + mix_sum_t'(pid_a_i);  // Sign extended
  assign sum_b = mix_sum_t'(asg_b_i) + mix_sum_t'(pid_b_i);

  assign mix_a_o = saturate(sum_a);
  assign mix_b_o = saturate(sum_b);

  ////////////////////
  // Checks
  ////////////////////

  // In range sums must pass through untouched
  always_comb begin
    if (sum_a >= SUM_MIN && sum_a <= SUM_MAX) begin
      assert (mix_a_o == sum_a[SAMPLE_W-1:0])
        else $error("mixer A altered an in-range sum");
    end
    if (sum_b >= SUM_MIN && sum_b <= SUM_MAX) begin
      assert (mix_b_o == sum_b[SAMPLE_W-1:0])
        else $error("mixer B altered an in-range sum");
    end
  end

endmodule

`default_nettype wire

// File: verification/tb_analog_top.sv
// Testbench for the analog data path top level
// Drives ADC, generator and controller inputs, keeps its own model
// of the averaging window and compares all outputs every cycle

`timescale 1ns/1ps
`default_nettype none

module tb_analog_top
  import analog_pkg::*;
();

  localparam int WIN        = 1 << WIN_LOG2_DEF;  // Default window
  localparam int SMP_MAX    = 2**(SAMPLE_W-1) - 1;
  localparam int SMP_MIN    = -(2**(SAMPLE_W-1));
  localparam int SETTLE_MAX = 2 * WIN + 8;        // Step wait limit

  logic      adc_clk;
  logic      adc_rstn;
  adc_raw_t  adc_dat_a;
  adc_raw_t  adc_dat_b;
  logic      digital_loop;
  sample_t   asg_a;
  sample_t   asg_b;
  sample_t   pid_a;
  sample_t   pid_b;
  sample_t   adc_a;
  sample_t   adc_b;
  dac_code_t dac_a;
  dac_code_t dac_b;
  logic      dac_sel;
  logic      dac_rst;

  // Reference model state
  sample_t             ref_hist [2][WIN];  // Mixed samples per channel
  int                  ref_ptr;
  logic [SAMPLE_W-1:0] ref_adc_code [2];   // Registered ADC codes
  dac_code_t           ref_dac [2];
  logic                ref_sel;
  logic                ref_rst;

  int     n_checks;
  int     n_mismatch;
  int     n_timeout;
  string  test_name;
  bit     checking;
  logic   prev_sel;
  logic   prev_rst;
  integer seed;

  analog_top dut0 (
    .adc_clk        (adc_clk),
    .adc_rstn       (adc_rstn),
    .adc_dat_a_i    (adc_dat_a),
    .adc_dat_b_i    (adc_dat_b),
    .digital_loop_i (digital_loop),
    .asg_a_i        (asg_a),
    .asg_b_i        (asg_b),
    .pid_a_i        (pid_a),
    .pid_b_i        (pid_b),
    .adc_a_o        (adc_a),
    .adc_b_o        (adc_b),
    .dac_a_o        (dac_a),
    .dac_b_o        (dac_b),
    .dac_sel_o      (dac_sel),
    .dac_rst_o      (dac_rst)
  );

  initial adc_clk = 1'b0;
  always #2 adc_clk = ~adc_clk;  // 4 ns period

  ////////////////////
  // Reference model
  ////////////////////

  function automatic sample_t sat_sum(input sample_t a, input sample_t b);
    int s;
    s = int'(a) + int'(b);
    if (s > SMP_MAX) s = SMP_MAX;  // Clamp high
    if (s < SMP_MIN) s = SMP_MIN;  // Clamp low
    return sample_t'(s);
  endfunction

  // Neg-slope code, all zeros is full positive scale
  function automatic sample_t adc_value(input logic [SAMPLE_W-1:0] code);
    return sample_t'(SMP_MAX - int'(code));
  endfunction

  function automatic dac_code_t dac_code(input sample_t v);
    return dac_code_t'(SMP_MAX - int'(v));
  endfunction

  // Window mean of one channel, floor
  function automatic sample_t ref_mean(input int ch);
    int acc;
    int q;
    acc = 0;
    for (int i = 0; i < WIN; i++) begin
      acc += int'(ref_hist[ch][i]);
    end
    q = acc / WIN;                            // Truncates toward zero
    if (acc < 0 && q * WIN != acc) q = q - 1;
    return sample_t'(q);
  endfunction

  always @(posedge adc_clk) begin
    if (!adc_rstn) begin
      for (int i = 0; i < WIN; i++) begin
        ref_hist[0][i] = '0;
        ref_hist[1][i] = '0;
      end
      ref_ptr         = 0;
      ref_adc_code[0] = '0;
      ref_adc_code[1] = '0;
      ref_dac[0]      = dac_code('0);
      ref_dac[1]      = dac_code('0);
      ref_sel         = 1'b0;
      ref_rst         = 1'b1;
    end else begin
      ref_dac[0] = dac_code(ref_mean(0));  // Mean before this edge
      ref_dac[1] = dac_code(ref_mean(1));
      ref_hist[0][ref_ptr] = sat_sum(asg_a, pid_a);
      ref_hist[1][ref_ptr] = sat_sum(asg_b, pid_b);
      ref_ptr = (ref_ptr + 1) % WIN;
      ref_adc_code[0] = adc_dat_a[ADC_RAW_W-1:ADC_RSV_W];
      ref_adc_code[1] = adc_dat_b[ADC_RAW_W-1:ADC_RSV_W];
      ref_sel = ~ref_sel;
      ref_rst = 1'b0;
    end
  end

  ////////////////////
  // Comparison
  ////////////////////

  task automatic report_mismatch(input string what, input logic signed [31:0] exp_v,
                                 input logic signed [31:0] act_v);
    n_mismatch++;
    $display("CHECK FAILED %s: %s expected %0d actual %0d at %0t",
             test_name, what, exp_v, act_v, $time);
  endtask

  // Mid cycle, away from the edge and the input updates
  always @(negedge adc_clk) begin
    sample_t exp_a;
    sample_t exp_b;
    if (checking) begin
      exp_a = digital_loop ? sat_sum(asg_a, pid_a) : adc_value(ref_adc_code[0]);
      exp_b = digital_loop ? sat_sum(asg_b, pid_b) : adc_value(ref_adc_code[1]);
      n_checks += 6;
      assert (adc_a === exp_a) else report_mismatch("adc_a_o", exp_a, adc_a);
      assert (adc_b === exp_b) else report_mismatch("adc_b_o", exp_b, adc_b);
      assert (dac_a === ref_dac[0]) else report_mismatch("dac_a_o", ref_dac[0], dac_a);
      assert (dac_b === ref_dac[1]) else report_mismatch("dac_b_o", ref_dac[1], dac_b);
      assert (dac_sel === ref_sel) else report_mismatch("dac_sel_o", ref_sel, dac_sel);
      assert (dac_rst === ref_rst) else report_mismatch("dac_rst_o", ref_rst, dac_rst);
      if (prev_rst === 1'b0) begin  // Strobe runs once DAC is out of reset
        n_checks++;
        assert (dac_sel !== prev_sel) else begin
          n_mismatch++;
          $display("ERROR in %s: dac_sel_o did not alternate at %0t", test_name, $time);
        end
      end
      prev_sel = dac_sel;
      prev_rst = dac_rst;
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic next_cycle();
    @(posedge adc_clk);
    #1;  // Inputs change just after the edge
  endtask

  function automatic sample_t rand_sample();
    integer r;
    r = $random(seed);
    return sample_t'(r);
  endfunction

  task automatic drive_mix(input int aa, input int pa, input int ab, input int pb);
    asg_a = sample_t'(aa);
    pid_a = sample_t'(pa);
    asg_b = sample_t'(ab);
    pid_b = sample_t'(pb);
  endtask

  task automatic wait_dac_reset_release();
    int n;
    n = 0;
    while (dac_rst !== 1'b0 && n < 8) begin
      next_cycle();
      n++;
    end
    if (dac_rst !== 1'b0) begin
      n_timeout++;
      $display("ERROR in %s: dac_rst_o never went low after reset release", test_name);
    end else begin
      assert (n == 1) else report_mismatch("release edges", 1, n);
    end
  endtask

  task automatic run_adc_conversion();
    adc_raw_t corners [4];
    corners = '{16'h0000, 16'hFFFF, 16'h7FFC, 16'h8003};  // Reserved bits vary too
    test_name = "adc_conversion";
    digital_loop = 1'b0;
    foreach (corners[i]) begin
      adc_dat_a = corners[i];
      adc_dat_b = ~corners[i];
      next_cycle();
    end
    repeat (200) begin
      adc_dat_a = adc_raw_t'($random(seed));
      adc_dat_b = adc_raw_t'($random(seed));
      next_cycle();
    end
  endtask

  task automatic run_loopback();
    int pairs [8][2];
    pairs = '{'{SMP_MAX, SMP_MAX}, '{SMP_MIN, SMP_MIN}, '{SMP_MAX, 1}, '{SMP_MIN, -1},
              '{100, -50}, '{4000, 4191}, '{-4096, -4096}, '{0, 0}};
    test_name = "loopback";
    digital_loop = 1'b1;
    foreach (pairs[i]) begin
      drive_mix(pairs[i][0], pairs[i][1], ~pairs[i][0], ~pairs[i][1]);  // B mirrored
      next_cycle();
    end
    repeat (200) begin
      asg_a = rand_sample();
      pid_a = rand_sample();
      asg_b = rand_sample();
      pid_b = rand_sample();
      next_cycle();
    end
  endtask

  // Hold one mixed value per channel until the DAC codes settle
  task automatic run_step(input int aa, input int pa, input int ab, input int pb);
    dac_code_t want_a;
    dac_code_t want_b;
    int        n;
    test_name = "step";
    digital_loop = 1'b0;
    drive_mix(aa, pa, ab, pb);
    want_a = dac_code(sat_sum(sample_t'(aa), sample_t'(pa)));
    want_b = dac_code(sat_sum(sample_t'(ab), sample_t'(pb)));
    n = 0;
    while ((dac_a !== want_a || dac_b !== want_b) && n < SETTLE_MAX) begin
      next_cycle();
      n++;
    end
    if (dac_a !== want_a || dac_b !== want_b) begin
      n_timeout++;
      $display("ERROR in %s: DAC outputs did not settle within %0d cycles",
               test_name, SETTLE_MAX);
    end
    repeat (8) next_cycle();  // Stays put once settled
  endtask

  task automatic run_random();
    integer r;
    test_name = "random_stream";
    repeat (2000) begin
      r = $random(seed);
      digital_loop = r[0];
      adc_dat_a = adc_raw_t'($random(seed));
      adc_dat_b = adc_raw_t'($random(seed));
      asg_a = rand_sample();
      pid_a = rand_sample();
      asg_b = rand_sample();
      pid_b = rand_sample();
      next_cycle();
    end
  endtask

  initial begin
    seed         = 82064;
    n_checks     = 0;
    n_mismatch   = 0;
    n_timeout    = 0;
    checking     = 1'b0;
    prev_sel     = 1'b0;
    prev_rst     = 1'b1;
    adc_rstn     = 1'b0;
    adc_dat_a    = '0;
    adc_dat_b    = '0;
    digital_loop = 1'b0;
    drive_mix(0, 0, 0, 0);
    test_name    = "reset";
    @(posedge adc_clk);
    #1;
    checking = 1'b1;  // DUT registers now defined
    repeat (7) next_cycle();
    adc_rstn = 1'b1;  // After 8 edges in reset
    wait_dac_reset_release();
    run_adc_conversion();
    run_loopback();
    run_step(3000, 1000, -5000, -4000);  // B clamps low
    run_step(-1, 0, 6000, 6000);         // Floor of -1, B clamps high
    run_step(0, 0, 0, 0);
    run_random();
    next_cycle();
    checking = 1'b0;
    $display("Summary: %0d checks, %0d mismatches, %0d timeouts",
             n_checks, n_mismatch, n_timeout);
    if (n_mismatch == 0 && n_timeout == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
hdl/analog_pkg.sv
hdl/adc_front.sv
hdl/output_mixer.sv
hdl/moving_average.sv
hdl/dac_output.sv
hdl/analog_top.sv
verification/tb_analog_top.sv
